/* build.f */
logic/spi_cfg_pkg.sv
logic/spi_proto_pkg.sv
logic/spi_clk_if.sv
logic/spi_sclk_gen.sv
logic/spi_shift_engine.sv
logic/spi_master.sv
tests/tb_clock.sv
tests/spi_master_tb.sv

/* logic/spi_cfg_pkg.sv */
`default_nettype none

package spi_cfg_pkg;

    // Frame size of the peripheral link
    localparam int word_bits = 16;

    // 48 MHz inner_clk divided down to a 4.8 MHz SCLK
    localparam int half_period_4m8_at_48m = 5;

    // Divider counter covers half periods up to 255
    localparam int half_period_width = 8;

    // Holds word_bits down to zero
    localparam int bit_count_width = 5;

endpackage

`default_nettype wire

/* logic/spi_clk_if.sv */
`default_nettype none

interface spi_clk_if;

    logic run;        // Engine requests SCLK activity
    logic sclk_level; // Registered SCLK pin level
    logic rise_tick;  // Level just went high
    logic fall_tick;  // Level just went low

    modport gen (
        input  run,
        output sclk_level,
        output rise_tick,
        output fall_tick
    );

    modport engine (
        output run,
        input  rise_tick,
        input  fall_tick
    );

endinterface

`default_nettype wire

/* logic/spi_master.sv */
`default_nettype none

module spi_master #(
    parameter int unsigned HALF_PERIOD = spi_cfg_pkg::half_period_4m8_at_48m,
    parameter logic        CS_ACTIVE   = 1'b1
) (
    input  logic                              inner_clk,
    input  logic                              reset,
    input  logic                              start_transfer,
    input  logic [spi_cfg_pkg::word_bits-1:0] tx_data,
    output logic [spi_cfg_pkg::word_bits-1:0] rx_data,
    output logic                              busy,
    output logic                              done,
    output logic                              sclk,
    output logic                              cs,
    output logic                              mosi,
    input  logic                              miso
);

    spi_clk_if clk_bus ();

    spi_sclk_gen #(
        .HALF_PERIOD (HALF_PERIOD)
    ) sclk_gen_i (
        .inner_clk (inner_clk),
        .reset     (reset),
        .clk_port  (clk_bus.gen)
    );

    spi_shift_engine #(
        .CS_ACTIVE (CS_ACTIVE)
    ) engine_i (
        .inner_clk      (inner_clk),
        .reset          (reset),
        .start_transfer (start_transfer),
        .tx_data        (tx_data),
        .rx_data        (rx_data),
        .busy           (busy),
        .done           (done),
        .cs             (cs),
        .mosi           (mosi),
        .miso           (miso),
        .clk_port       (clk_bus.engine)
    );

    assign sclk = clk_bus.sclk_level; // Registered SCLK level from the divider

endmodule

`default_nettype wire

/* logic/spi_proto_pkg.sv */
`default_nettype none

package spi_proto_pkg;

    typedef enum logic [1:0] {
        st_idle,
        st_select,
        st_transfer,
        st_deselect
    } spi_state_t;

    // Link sends and receives least significant bit first
    localparam bit lsb_first = 1'b1;

endpackage

`default_nettype wire

/* logic/spi_sclk_gen.sv */
`default_nettype none

module spi_sclk_gen #(
    parameter int unsigned HALF_PERIOD = spi_cfg_pkg::half_period_4m8_at_48m
) (
    input logic      inner_clk,
    input logic      reset,
    spi_clk_if.gen   clk_port
);

    localparam int cnt_w = spi_cfg_pkg::half_period_width;
    localparam logic [cnt_w-1:0] last_count = cnt_w'(HALF_PERIOD - 1);

    logic [cnt_w-1:0] half_count;

    // SCLK stays on inner_clk as a level plus edge strobes
    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            half_count           <= '0;
            clk_port.sclk_level  <= 1'b0;
            clk_port.rise_tick   <= 1'b0;
            clk_port.fall_tick   <= 1'b0;
        end else if (!clk_port.run) begin
            half_count           <= '0; // Mode 0 idles low
            clk_port.sclk_level  <= 1'b0;
            clk_port.rise_tick   <= 1'b0;
            clk_port.fall_tick   <= 1'b0;
        end else if (half_count == last_count) begin
            half_count           <= '0;
            clk_port.sclk_level  <= ~clk_port.sclk_level;
            clk_port.rise_tick   <= ~clk_port.sclk_level;
            clk_port.fall_tick   <= clk_port.sclk_level;
        end else begin
            half_count           <= half_count + 1'b1;
            clk_port.rise_tick   <= 1'b0;
            clk_port.fall_tick   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/spi_shift_engine.sv */
`default_nettype none

module spi_shift_engine #(
    parameter logic CS_ACTIVE = 1'b1
) (
    input  logic                              inner_clk,
    input  logic                              reset,
    input  logic                              start_transfer,
    input  logic [spi_cfg_pkg::word_bits-1:0] tx_data,
    output logic [spi_cfg_pkg::word_bits-1:0] rx_data,
    output logic                              busy,
    output logic                              done,
    output logic                              cs,
    output logic                              mosi,
    input  logic                              miso,
    spi_clk_if.engine                         clk_port
);

    localparam int msb = spi_cfg_pkg::word_bits - 1;
    localparam int cnt_w = spi_cfg_pkg::bit_count_width;

    spi_proto_pkg::spi_state_t state;

    logic [msb:0]       tx_shift;
    logic [msb:0]       rx_shift;
    logic [cnt_w-1:0]   bit_count; // Rising edges still to come

    assign busy = (state != spi_proto_pkg::st_idle);
    assign done = (state == spi_proto_pkg::st_deselect);
    assign clk_port.run = (state == spi_proto_pkg::st_transfer);

    assign mosi = spi_proto_pkg::lsb_first ? tx_shift[0] : tx_shift[msb];

    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            state     <= spi_proto_pkg::st_idle;
            cs        <= ~CS_ACTIVE;
            rx_data   <= '0;
            tx_shift  <= '0;
            rx_shift  <= '0;
            bit_count <= '0;
        end else begin
            case (state)
                spi_proto_pkg::st_idle: begin
                    if (start_transfer) begin
                        tx_shift  <= tx_data; // Bit 0 on mosi during select
                        bit_count <= cnt_w'(spi_cfg_pkg::word_bits);
                        cs        <= CS_ACTIVE;
                        state     <= spi_proto_pkg::st_select;
                    end
                end

                spi_proto_pkg::st_select: begin
                    state <= spi_proto_pkg::st_transfer;
                end

                spi_proto_pkg::st_transfer: begin
                    if (clk_port.rise_tick) begin
                        if (spi_proto_pkg::lsb_first) begin
                            rx_shift <= {miso, rx_shift[msb:1]};
                        end else begin
                            rx_shift <= {rx_shift[msb-1:0], miso};
                        end
                        bit_count <= bit_count - 1'b1;
                    end
                    if (clk_port.fall_tick) begin
                        if (spi_proto_pkg::lsb_first) begin
                            tx_shift <= {1'b0, tx_shift[msb:1]};
                        end else begin
                            tx_shift <= {tx_shift[msb-1:0], 1'b0};
                        end
                        // Last falling edge closes the frame
                        if (bit_count == '0) begin
                            cs      <= ~CS_ACTIVE;
                            rx_data <= rx_shift;
                            state   <= spi_proto_pkg::st_deselect;
                        end
                    end
                end

                spi_proto_pkg::st_deselect: begin
                    state <= spi_proto_pkg::st_idle; // Done pulse lasts one cycle
                end

                default: begin
                    state <= spi_proto_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f build.f --top-module spi_master_tb \
    -Mdir obj_dir -o spi_master_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/spi_master_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$log"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

/* tests/spi_golden.txt */
# Columns (hex): tx word, slave word, start-while-busy flag
# Expected rx_data is the slave word, expected slave capture is the tx word
A5C3 3C5A 0
0001 8000 0
FFFF 0000 1
0000 FFFF 0
1234 ABCD 0
8001 7FFE 1
DEAD BEEF 0
55AA AA55 1
F00F 0FF0 0
C0DE 1357 0

/* tests/spi_master_tb.sv */
`default_nettype none

module spi_master_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned half_period = 5;
    localparam logic        cs_active   = 1'b1;
    localparam logic        cs_idle     = ~cs_active;
    localparam int          word_bits   = spi_cfg_pkg::word_bits;

    logic                 inner_clk;
    logic                 reset;
    logic                 start_transfer;
    logic [word_bits-1:0] tx_data;
    logic [word_bits-1:0] rx_data;
    logic                 busy;
    logic                 done;
    logic                 sclk;
    logic                 cs;
    logic                 mosi;
    logic                 miso = 1'b0;

    logic [word_bits-1:0] tx_q[$];
    logic [word_bits-1:0] slave_q[$];
    logic                 flag_q[$];
    logic                 golden_ok = 1'b0;

    int          error_count    = 0;
    int          check_count    = 0;
    int          frames_done    = 0;
    int          cycle_count    = 0;
    int          timeout_cycles = 200;
    logic [31:0] rng_state      = 32'h233f;
    logic [word_bits-1:0] prev_rx = '0; // Word rx_data must hold between frames

    // Slave model state
    logic                 sclk_prev = 1'b0;
    logic                 cs_prev   = cs_idle;
    logic [word_bits-1:0] slave_word = '0;
    logic [word_bits-1:0] capture    = '0;
    int                   rise_count = 0;
    int                   bit_idx    = 0;

    tb_clock #(
        .period_ns    (20),
        .reset_cycles (8)
    ) clock_gen_i (
        .inner_clk (inner_clk),
        .reset     (reset)
    );

    spi_master #(
        .HALF_PERIOD (half_period),
        .CS_ACTIVE   (cs_active)
    ) dut_i (
        .inner_clk      (inner_clk),
        .reset          (reset),
        .start_transfer (start_transfer),
        .tx_data        (tx_data),
        .rx_data        (rx_data),
        .busy           (busy),
        .done           (done),
        .sclk           (sclk),
        .cs             (cs),
        .mosi           (mosi),
        .miso           (miso)
    );

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Position in the word of the n-th bit on the wire
    function automatic int bit_position(input int n);
        return spi_proto_pkg::lsb_first ? n : word_bits - 1 - n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: expected 0x%0h, actual 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d frames, %0d checks, %0d errors",
                 frames_done, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic read_golden();
        int                   fd;
        int                   n;
        string                line;
        logic [word_bits-1:0] tx;
        logic [word_bits-1:0] sw;
        logic [3:0]           flag;
        fd = $fopen("tests/spi_golden.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%h %h %h", tx, sw, flag) == 3) begin
                        tx_q.push_back(tx);
                        slave_q.push_back(sw);
                        flag_q.push_back(flag != 4'h0);
                    end
                end
            end
            $fclose(fd);
            golden_ok = (tx_q.size() > 0);
        end
    endtask

    task automatic check_idle();
        check_value("sclk", 32'd0, 32'(sclk));
        check_value("cs", 32'(cs_idle), 32'(cs));
        check_value("busy", 32'd0, 32'(busy));
        check_value("done", 32'd0, 32'(done));
        check_value("rx_data", 32'(prev_rx), 32'(rx_data));
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge inner_clk);
            #2;
            check_idle();
        end
    endtask

    task automatic run_frame(input int idx);
        logic [word_bits-1:0] tx;
        logic [word_bits-1:0] sw;
        int                   gap;
        int                   k;
        tx = tx_q[idx];
        sw = slave_q[idx];
        gap = (idx == 1) ? 1 : int'(next_random() % 32'd8) + 1; // Frame 1 starts right after done
        idle_cycles(gap);
        slave_word = sw;
        start_transfer = 1'b1;
        tx_data = tx;
        @(posedge inner_clk);
        #2;
        start_transfer = 1'b0;
        k = 0;
        while (done !== 1'b1) begin
            check_value("busy", 32'd1, 32'(busy));
            check_value("rx_data", 32'(prev_rx), 32'(rx_data));
            if (flag_q[idx] && k == 40) begin
                start_transfer = 1'b1; // Stray start mid-frame
                tx_data = ~tx;
            end else begin
                start_transfer = 1'b0;
            end
            @(posedge inner_clk);
            #2;
            k++;
        end
        start_transfer = 1'b0;
        check_value("busy", 32'd1, 32'(busy));
        check_value("cs", 32'(cs_idle), 32'(cs));
        check_value("rx_data", 32'(sw), 32'(rx_data));
        check_value("slave capture", 32'(tx), 32'(capture));
        check_value("sclk rise count", 32'(word_bits), 32'(rise_count));
        prev_rx = sw;
        frames_done++;
    endtask

    // Slave model samples and drives just after each clock edge
    always @(posedge inner_clk) begin
        #2;
        if (reset) begin
            sclk_prev = 1'b0;
            cs_prev   = cs_idle;
        end else begin
            if (cs != cs_active) begin
                check_value("sclk while cs inactive", 32'd0, 32'(sclk));
            end
            if (cs == cs_active && cs_prev != cs_active) begin
                bit_idx    = 0;
                rise_count = 0;
                capture    = '0;
                miso       = slave_word[bit_position(0)];
            end
            if (sclk && !sclk_prev) begin
                check_value("cs at sclk rise", 32'(cs_active), 32'(cs));
                if (cs == cs_active) begin
                    if (rise_count < word_bits) begin
                        capture[bit_position(rise_count)] = mosi;
                    end
                    rise_count++;
                end
            end
            if (!sclk && sclk_prev && cs == cs_active) begin
                bit_idx++;
                if (bit_idx < word_bits) begin
                    miso = slave_word[bit_position(bit_idx)]; // Next bit after falling edge
                end
            end
            sclk_prev = sclk;
            cs_prev   = cs;
        end
    end

    always @(posedge inner_clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the DUT gave no done within %0d cycles", cycle_count);
            error_count++;
            finish_run();
        end
    end

    initial begin
        start_transfer = 1'b0;
        tx_data        = '0;
        read_golden();
        timeout_cycles = tx_q.size() * (2 + 32 * half_period + 8 + 4) + 200;
        if (!golden_ok) begin
            $display("Error: golden file tests/spi_golden.txt is missing or holds no frames");
            error_count++;
        end else begin
            repeat (4) begin
                @(posedge inner_clk);
                #2;
                check_idle(); // Still in reset
            end
            @(negedge reset);
            @(posedge inner_clk);
            #2;
            check_idle();
            for (int i = 0; i < tx_q.size(); i++) begin
                run_frame(i);
            end
            idle_cycles(2);
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 8
) (
    output logic inner_clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        inner_clk = 1'b0;
        forever #(period_ns / 2) inner_clk = ~inner_clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge inner_clk);
        #2 reset = 1'b0; // Released just after an edge
    end

endmodule

`default_nettype wire
